// ==== design/load_writeback.sv ====
// Load result merge, byte lane alignment, sign or zero extension and id tagging
`timescale 1ns/1ns
`default_nettype none

module load_writeback (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           load_issue,
    input  wire logic [1:0]                     load_byte_addr,
    input  wire ls_op_pkg::ls_op_t              load_op,
    input  wire ls_config_pkg::ls_target_t      load_target,
    input  wire logic [ls_config_pkg::ID_W-1:0] id,
    input  wire logic                           local_load_valid,
    input  wire logic [ls_config_pkg::XLEN-1:0] local_load_data,
    input  wire logic                           periph_load_valid,
    input  wire logic [ls_config_pkg::XLEN-1:0] periph_load_data,
    output logic                                wb_done,
    output logic [ls_config_pkg::ID_W-1:0]      wb_id,
    output logic [ls_config_pkg::XLEN-1:0]      wb_rd
);
    import ls_config_pkg::*;
    import ls_op_pkg::*;

    logic [1:0]      byte_q;
    ls_op_t          op_q;
    ls_target_t      target_q;
    logic [ID_W-1:0] id_q;
    logic            attr_valid;
    logic            result_valid;
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] shifted;

    // One load outstanding at a time, the issue side holds on a switch
    always_ff @(posedge clk) begin
        if (load_issue) begin
            byte_q   <= load_byte_addr;
            op_q     <= load_op;
            target_q <= load_target;
            id_q     <= id;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            attr_valid <= 1'b0;
        else if (load_issue)
            attr_valid <= 1'b1;
        else if (wb_done)
            attr_valid <= 1'b0;
    end

    ////////////////////////////////////////////////////////////
    // Result select and alignment
    assign result_valid = (target_q == LOCAL_SRC) ? local_load_valid : periph_load_valid;
    assign wb_done      = attr_valid & result_valid;
    assign word         = local_load_valid ? local_load_data : periph_load_data;
    assign shifted      = word >> {byte_q, 3'b000};

    always_comb begin
        case (op_q)
            OP_LB:   wb_rd = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            OP_LH:   wb_rd = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            OP_LBU:  wb_rd = {{(XLEN-8){1'b0}}, shifted[7:0]};
            OP_LHU:  wb_rd = {{(XLEN-16){1'b0}}, shifted[15:0]};
            default: wb_rd = shifted;
        endcase
    end

    assign wb_id = id_q;

endmodule

`default_nettype wire

// ==== design/local_mem_unit.sv ====
// Byte-writable local data memory with a one-cycle registered read
`timescale 1ns/1ns
`default_nettype none

module local_mem_unit #(
    parameter int LOCAL_MEM_WORDS = 256
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic                           req,
    input  wire logic                           we,
    input  wire logic [ls_config_pkg::XLEN/8-1:0] be,
    input  wire logic [ls_config_pkg::XLEN-3:0] addr,
    input  wire logic [ls_config_pkg::XLEN-1:0] wdata,
    output logic                                load_valid,
    output logic [ls_config_pkg::XLEN-1:0]      load_data
);
    import ls_config_pkg::*;

    localparam int IDX_W = $clog2(LOCAL_MEM_WORDS);

    logic [XLEN-1:0]  mem [LOCAL_MEM_WORDS];
    logic [IDX_W-1:0] idx;

    // Word index wraps modulo the depth
    assign idx = addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (req & we) begin
            for (int i = 0; i < XLEN/8; i++) begin
                if (be[i])
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
        if (req & ~we)
            load_data <= mem[idx];
    end

    // Valid follows the read request by one cycle
    always_ff @(posedge clk) begin
        if (rst)
            load_valid <= 1'b0;
        else
            load_valid <= req & ~we;
    end

endmodule

`default_nettype wire

// ==== design/ls_config_pkg.sv ====
// Address map, data and id widths, and the data source select type
`default_nettype none

package ls_config_pkg;

    // Data path and address width
    localparam int XLEN = 32;

    // Instruction id width
    localparam int ID_W = 4;

    // Peripheral region starts here, everything below is local memory
    localparam logic [XLEN-1:0] PERIPH_BASE = 32'h8000_0000;

    typedef enum logic {
        LOCAL_SRC  = 1'b0,
        PERIPH_SRC = 1'b1
    } ls_target_t;

endpackage

`default_nettype wire

// ==== design/ls_issue.sv ====
// Address generation, byte enables, alignment check, source select, switch hold, exceptions
`timescale 1ns/1ns
`default_nettype none

module ls_issue (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             new_request,
    input  wire ls_op_pkg::ls_op_t                op,
    input  wire logic [ls_config_pkg::XLEN-1:0]   base,
    input  wire logic [11:0]                      offset,
    input  wire logic [ls_config_pkg::XLEN-1:0]   store_data,
    input  wire logic [ls_config_pkg::ID_W-1:0]   id,
    input  wire logic                             periph_busy,
    output logic                                  ready,
    output logic                                  exc_valid,
    output ls_op_pkg::exc_code_t                  exc_code,
    output logic [ls_config_pkg::XLEN-1:0]        exc_tval,
    output logic [ls_config_pkg::ID_W-1:0]        exc_id,
    output logic                                  local_req,
    output logic                                  local_we,
    output logic [ls_config_pkg::XLEN/8-1:0]      local_be,
    output logic [ls_config_pkg::XLEN-1:0]        local_wdata,
    output logic                                  periph_req,
    output logic                                  periph_we,
    output logic [ls_config_pkg::XLEN/8-1:0]      periph_be,
    output logic [ls_config_pkg::XLEN-1:0]        periph_wdata,
    output logic [ls_config_pkg::XLEN-3:0]        mem_addr,
    output logic                                  load_issue,
    output logic [1:0]                            load_byte_addr,
    output ls_op_pkg::ls_op_t                     load_op,
    output ls_config_pkg::ls_target_t             load_target
);
    import ls_config_pkg::*;
    import ls_op_pkg::*;

    logic [XLEN-1:0]   eff_addr;
    ls_size_t          size;
    logic              is_store;
    logic              misaligned;
    ls_target_t        target;
    logic [XLEN/8-1:0] be;
    logic [XLEN-1:0]   wdata;
    logic              accept;
    logic              load_accept;
    logic              local_pending;
    ls_target_t        last_target;
    logic              switch_hold;

    ////////////////////////////////////////////////////////////
    // Address generation and decode
    assign eff_addr = base + {{(XLEN-12){offset[11]}}, offset};
    assign size     = ls_size_t'(op[1:0]);
    assign is_store = op[3];
    assign target   = (eff_addr >= PERIPH_BASE) ? PERIPH_SRC : LOCAL_SRC;
    assign mem_addr = eff_addr[XLEN-1:2];

    always_comb begin
        case (size)
            SIZE_H:  misaligned = eff_addr[0];
            SIZE_W:  misaligned = |eff_addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // Store data replicated over all lanes, the enables pick the live ones
    always_comb begin
        be = '0;
        case (size)
            SIZE_B: begin
                be[eff_addr[1:0]] = 1'b1;
                wdata = {(XLEN/8){store_data[7:0]}};
            end
            SIZE_H: begin
                be[{eff_addr[1], 1'b0}] = 1'b1;
                be[{eff_addr[1], 1'b1}] = 1'b1;
                wdata = {(XLEN/16){store_data[15:0]}};
            end
            default: begin
                be    = '1;
                wdata = store_data;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Issue control
    assign accept      = new_request & ready;
    assign load_accept = accept & ~is_store & ~misaligned;

    // A load to the other source waits until the previous load has returned
    assign switch_hold = new_request & ~is_store & ~misaligned
                       & (local_pending | periph_busy) & (target != last_target);
    assign ready       = ~periph_busy & ~switch_hold;

    always_ff @(posedge clk) begin
        if (rst) begin
            local_pending <= 1'b0;
            last_target   <= LOCAL_SRC;
        end else begin
            // Local loads return after exactly one cycle
            local_pending <= load_accept & (target == LOCAL_SRC);
            if (load_accept)
                last_target <= target;
        end
    end

    // Source requests
    assign local_req    = accept & ~misaligned & (target == LOCAL_SRC);
    assign local_we     = is_store;
    assign local_be     = be;
    assign local_wdata  = wdata;
    assign periph_req   = accept & ~misaligned & (target == PERIPH_SRC);
    assign periph_we    = is_store;
    assign periph_be    = be;
    assign periph_wdata = wdata;

    // Load attributes for writeback
    assign load_issue     = load_accept;
    assign load_byte_addr = eff_addr[1:0];
    assign load_op        = op;
    assign load_target    = target;

    ////////////////////////////////////////////////////////////
    // Misaligned access exception
    always_ff @(posedge clk) begin
        if (rst)
            exc_valid <= 1'b0;
        else
            exc_valid <= accept & misaligned;
    end

    always_ff @(posedge clk) begin
        if (accept & misaligned) begin
            exc_code <= is_store ? STORE_ADDR_MISALIGNED : LOAD_ADDR_MISALIGNED;
            exc_tval <= eff_addr;
            exc_id   <= id;
        end
    end

endmodule

`default_nettype wire

// ==== design/ls_op_pkg.sv ====
// Memory opcode, access size and exception code enums
`default_nettype none

package ls_op_pkg;

    // Low three bits follow funct3, bit 3 marks a store
    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LH  = 4'b0001,
        OP_LW  = 4'b0010,
        OP_LBU = 4'b0100,
        OP_LHU = 4'b0101,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1001,
        OP_SW  = 4'b1010
    } ls_op_t;

    // Taken from the low two opcode bits
    typedef enum logic [1:0] {
        SIZE_B = 2'b00,
        SIZE_H = 2'b01,
        SIZE_W = 2'b10
    } ls_size_t;

    typedef enum logic [3:0] {
        LOAD_ADDR_MISALIGNED  = 4'd4,
        STORE_ADDR_MISALIGNED = 4'd6
    } exc_code_t;

endpackage

`default_nettype wire

// ==== design/ls_unit.sv ====
// Load/store unit top level with issue, local memory, peripheral bus and writeback
`timescale 1ns/1ns
`default_nettype none

module ls_unit #(
    parameter int LOCAL_MEM_WORDS = 256
) (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             new_request,
    input  wire ls_op_pkg::ls_op_t                op,
    input  wire logic [ls_config_pkg::XLEN-1:0]   base,
    input  wire logic [11:0]                      offset,
    input  wire logic [ls_config_pkg::XLEN-1:0]   store_data,
    input  wire logic [ls_config_pkg::ID_W-1:0]   id,
    output logic                                  ready,
    output logic                                  wb_done,
    output logic [ls_config_pkg::ID_W-1:0]        wb_id,
    output logic [ls_config_pkg::XLEN-1:0]        wb_rd,
    output logic                                  exc_valid,
    output ls_op_pkg::exc_code_t                  exc_code,
    output logic [ls_config_pkg::XLEN-1:0]        exc_tval,
    output logic [ls_config_pkg::ID_W-1:0]        exc_id,
    output logic                                  bus_req,
    output logic                                  bus_we,
    output logic [ls_config_pkg::XLEN-1:0]        bus_addr,
    output logic [ls_config_pkg::XLEN/8-1:0]      bus_be,
    output logic [ls_config_pkg::XLEN-1:0]        bus_wdata,
    input  wire logic                             bus_ack,
    input  wire logic [ls_config_pkg::XLEN-1:0]   bus_rdata
);
    import ls_config_pkg::*;
    import ls_op_pkg::*;

    logic [XLEN-3:0]   mem_addr;
    logic              local_req;
    logic              local_we;
    logic [XLEN/8-1:0] local_be;
    logic [XLEN-1:0]   local_wdata;
    logic              periph_req;
    logic              periph_we;
    logic [XLEN/8-1:0] periph_be;
    logic [XLEN-1:0]   periph_wdata;
    logic              periph_busy;
    logic              load_issue;
    logic [1:0]        load_byte_addr;
    ls_op_t            load_op;
    ls_target_t        load_target;
    logic              local_load_valid;
    logic [XLEN-1:0]   local_load_data;
    logic              periph_load_valid;
    logic [XLEN-1:0]   periph_load_data;

    ////////////////////////////////////////////////////////////
    // Issue stage
    ls_issue u_issue (
        .clk            (clk),
        .rst            (rst),
        .new_request    (new_request),
        .op             (op),
        .base           (base),
        .offset         (offset),
        .store_data     (store_data),
        .id             (id),
        .periph_busy    (periph_busy),
        .ready          (ready),
        .exc_valid      (exc_valid),
        .exc_code       (exc_code),
        .exc_tval       (exc_tval),
        .exc_id         (exc_id),
        .local_req      (local_req),
        .local_we       (local_we),
        .local_be       (local_be),
        .local_wdata    (local_wdata),
        .periph_req     (periph_req),
        .periph_we      (periph_we),
        .periph_be      (periph_be),
        .periph_wdata   (periph_wdata),
        .mem_addr       (mem_addr),
        .load_issue     (load_issue),
        .load_byte_addr (load_byte_addr),
        .load_op        (load_op),
        .load_target    (load_target)
    );

    ////////////////////////////////////////////////////////////
    // Data sources
    local_mem_unit #(
        .LOCAL_MEM_WORDS (LOCAL_MEM_WORDS)
    ) u_local_mem (
        .clk        (clk),
        .rst        (rst),
        .req        (local_req),
        .we         (local_we),
        .be         (local_be),
        .addr       (mem_addr),
        .wdata      (local_wdata),
        .load_valid (local_load_valid),
        .load_data  (local_load_data)
    );

    periph_bus_unit u_periph_bus (
        .clk        (clk),
        .rst        (rst),
        .req        (periph_req),
        .we         (periph_we),
        .be         (periph_be),
        .addr       (mem_addr),
        .wdata      (periph_wdata),
        .bus_ack    (bus_ack),
        .bus_rdata  (bus_rdata),
        .busy       (periph_busy),
        .load_valid (periph_load_valid),
        .load_data  (periph_load_data),
        .bus_req    (bus_req),
        .bus_we     (bus_we),
        .bus_addr   (bus_addr),
        .bus_be     (bus_be),
        .bus_wdata  (bus_wdata)
    );

    ////////////////////////////////////////////////////////////
    // Writeback
    load_writeback u_writeback (
        .clk               (clk),
        .rst               (rst),
        .load_issue        (load_issue),
        .load_byte_addr    (load_byte_addr),
        .load_op           (load_op),
        .load_target       (load_target),
        .id                (id),
        .local_load_valid  (local_load_valid),
        .local_load_data   (local_load_data),
        .periph_load_valid (periph_load_valid),
        .periph_load_data  (periph_load_data),
        .wb_done           (wb_done),
        .wb_id             (wb_id),
        .wb_rd             (wb_rd)
    );

endmodule

`default_nettype wire

// ==== design/periph_bus_unit.sv ====
// Four-phase req/ack bus master for the peripheral address region
`timescale 1ns/1ns
`default_nettype none

module periph_bus_unit (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             req,
    input  wire logic                             we,
    input  wire logic [ls_config_pkg::XLEN/8-1:0] be,
    input  wire logic [ls_config_pkg::XLEN-3:0]   addr,
    input  wire logic [ls_config_pkg::XLEN-1:0]   wdata,
    input  wire logic                             bus_ack,
    input  wire logic [ls_config_pkg::XLEN-1:0]   bus_rdata,
    output logic                                  busy,
    output logic                                  load_valid,
    output logic [ls_config_pkg::XLEN-1:0]        load_data,
    output logic                                  bus_req,
    output logic                                  bus_we,
    output logic [ls_config_pkg::XLEN-1:0]        bus_addr,
    output logic [ls_config_pkg::XLEN/8-1:0]      bus_be,
    output logic [ls_config_pkg::XLEN-1:0]        bus_wdata
);
    import ls_config_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RELEASE,
        DONE
    } bus_state_t;

    bus_state_t state;

    ////////////////////////////////////////////////////////////
    // Handshake FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (req)
                        state <= WAIT_ACK;
                end
                WAIT_ACK: begin
                    if (bus_ack)
                        state <= WAIT_RELEASE;
                end
                // req is already low here, wait for the slave to drop ack
                WAIT_RELEASE: begin
                    if (~bus_ack)
                        state <= DONE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and data held stable for the whole transfer
    always_ff @(posedge clk) begin
        if ((state == IDLE) & req) begin
            bus_we    <= we;
            bus_addr  <= {addr, 2'b00};
            bus_be    <= be;
            bus_wdata <= wdata;
        end
    end

    // Read data is only valid while ack is high
    always_ff @(posedge clk) begin
        if ((state == WAIT_ACK) & bus_ack)
            load_data <= bus_rdata;
    end

    assign bus_req    = (state == WAIT_ACK);
    assign busy       = (state != IDLE);
    assign load_valid = (state == DONE) & ~bus_we;

endmodule

`default_nettype wire

// ==== ls_unit.f ====
design/ls_config_pkg.sv
design/ls_op_pkg.sv
design/ls_issue.sv
design/local_mem_unit.sv
design/periph_bus_unit.sv
design/load_writeback.sv
design/ls_unit.sv
sim/periph_responder.sv
sim/ls_unit_tb.sv

// ==== sim/ls_unit_stimulus.txt ====
# index opcode base offset store_data id kind(0 none 1 writeback 2 exception) expected tval
# all hex, opcode LB 0 LH 1 LW 2 LBU 4 LHU 5 SB 8 SH 9 SW a
01 a 00000100 000 80f17e92 1 0 00000000 00000000
02 2 00000100 000 00000000 2 1 80f17e92 00000000
03 1 00000100 000 00000000 3 1 00007e92 00000000
04 1 00000100 002 00000000 4 1 ffff80f1 00000000
05 5 00000100 002 00000000 5 1 000080f1 00000000
06 0 00000100 000 00000000 6 1 ffffff92 00000000
07 0 00000100 001 00000000 7 1 0000007e 00000000
08 0 00000100 002 00000000 8 1 fffffff1 00000000
09 0 00000100 003 00000000 9 1 ffffff80 00000000
0a 4 00000100 000 00000000 a 1 00000092 00000000
0b 4 00000100 003 00000000 b 1 00000080 00000000
0c 4 00000100 001 00000000 c 1 0000007e 00000000
0d a 00000108 ffc 11223344 d 0 00000000 00000000
0e 8 00000104 001 000000aa e 0 00000000 00000000
0f 9 00000104 002 0000bbcc f 0 00000000 00000000
10 2 00000104 000 00000000 0 1 bbccaa44 00000000
11 a 80000010 000 cafe1234 1 0 00000000 00000000
12 8 80000010 003 0000005a 2 0 00000000 00000000
13 2 80000010 000 00000000 3 1 5afe1234 00000000
14 1 80000010 002 00000000 4 1 00005afe 00000000
15 0 80000010 001 00000000 5 1 00000012 00000000
16 4 80000010 003 00000000 6 1 0000005a 00000000
17 1 00000100 001 00000000 6 2 00000004 00000101
18 2 00000100 002 00000000 7 2 00000004 00000102
19 9 00000100 003 0000dead 8 2 00000006 00000103
1a a 00000104 001 deadbeef 9 2 00000006 00000105
1b 2 00000100 000 00000000 a 1 80f17e92 00000000
1c 2 00000104 000 00000000 b 1 bbccaa44 00000000
1d 2 80000010 000 00000000 c 1 5afe1234 00000000
1e 2 00000100 000 00000000 d 1 80f17e92 00000000
1f 5 80000010 002 00000000 e 1 00005afe 00000000
20 0 00000104 000 00000000 f 1 00000044 00000000

// ==== sim/ls_unit_tb.sv ====
// Testbench for the load/store unit with file stimulus, result checks, watchdog and summary
`timescale 1ns/1ns
`default_nettype none

module ls_unit_tb;
    import ls_config_pkg::*;
    import ls_op_pkg::*;

    logic              clk;
    logic              rst;
    logic              new_request;
    ls_op_t            op;
    logic [XLEN-1:0]   base;
    logic [11:0]       offset;
    logic [XLEN-1:0]   store_data;
    logic [ID_W-1:0]   id;
    logic              ready;
    logic              wb_done;
    logic [ID_W-1:0]   wb_id;
    logic [XLEN-1:0]   wb_rd;
    logic              exc_valid;
    exc_code_t         exc_code;
    logic [XLEN-1:0]   exc_tval;
    logic [ID_W-1:0]   exc_id;
    logic              bus_req;
    logic              bus_we;
    logic [XLEN-1:0]   bus_addr;
    logic [XLEN/8-1:0] bus_be;
    logic [XLEN-1:0]   bus_wdata;
    logic              bus_ack;
    logic [XLEN-1:0]   bus_rdata;

    // Test table read from the stimulus file
    logic [31:0] t_idx [64];
    logic [31:0] t_op [64];
    logic [31:0] t_base [64];
    logic [31:0] t_off [64];
    logic [31:0] t_data [64];
    logic [31:0] t_id [64];
    logic [31:0] t_kind [64];
    logic [31:0] t_exp [64];
    logic [31:0] t_tval [64];
    int          num_tests = 0;
    bit          loaded = 1'b0;

    // Pending results in issue order
    int q_test [$];
    int q_cycle [$];
    int q_local [$];

    int cycle = 0;
    int errors = 0;
    int passed = 0;

    ls_unit #(.LOCAL_MEM_WORDS(256)) uut (
        .clk(clk), .rst(rst), .new_request(new_request), .op(op), .base(base),
        .offset(offset), .store_data(store_data), .id(id), .ready(ready),
        .wb_done(wb_done), .wb_id(wb_id), .wb_rd(wb_rd), .exc_valid(exc_valid),
        .exc_code(exc_code), .exc_tval(exc_tval), .exc_id(exc_id),
        .bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr), .bus_be(bus_be),
        .bus_wdata(bus_wdata), .bus_ack(bus_ack), .bus_rdata(bus_rdata)
    );

    periph_responder u_responder (
        .clk(clk), .rst(rst), .bus_req(bus_req), .bus_we(bus_we), .bus_addr(bus_addr),
        .bus_be(bus_be), .bus_wdata(bus_wdata), .bus_ack(bus_ack), .bus_rdata(bus_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    initial begin
        wait (loaded);
        #(num_tests * 20 * 20);
        $display("Watchdog expired before all tests finished");
        $display("=== FAIL ===");
        $finish;
    end

    task automatic compare_field(input int t, input string field, input logic [31:0] exp_v,
                                 input logic [31:0] act_v, inout bit ok);
        if (exp_v !== act_v) begin
            $display("** Error test %0d %s: expected %h actual %h", t, field, exp_v, act_v);
            errors++;
            ok = 0;
        end
    endtask

    task automatic check_pulse(input int kind, input logic [31:0] val, input logic [31:0] tval,
                               input logic [31:0] rid);
        int t;
        int acc;
        int is_local;
        bit ok;
        if (q_test.size() == 0) begin
            $display("Unexpected %s pulse with no test waiting",
                     kind == 1 ? "wb_done" : "exc_valid");
            errors++;
            return;
        end
        t = q_test.pop_front();
        acc = q_cycle.pop_front();
        is_local = q_local.pop_front();
        ok = 1;
        if (t_kind[t] != kind) begin
            $display("Test %0d got a %s pulse it should not produce", t_idx[t],
                     kind == 1 ? "wb_done" : "exc_valid");
            errors++;
            return;
        end
        compare_field(t_idx[t], kind == 1 ? "data" : "code", t_exp[t], val, ok);
        compare_field(t_idx[t], "id", t_id[t], rid, ok);
        if (kind == 2)
            compare_field(t_idx[t], "tval", t_tval[t], tval, ok);
        // Local loads and exceptions answer in the cycle after the accepting edge
        if (is_local)
            compare_field(t_idx[t], "cycle", acc, cycle, ok);
        if (ok) begin
            passed++;
            $display("Test %0d ok", t_idx[t]);
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (wb_done)
                check_pulse(1, wb_rd, 0, wb_id);
            if (exc_valid)
                check_pulse(2, exc_code, exc_tval, exc_id);
        end
    end

    initial begin
        int          fd;
        int          n;
        int          waits;
        int          exp_waits;
        bit          hold_ok;
        bit          prev_local_load;
        bit          prev_periph;
        string       line;
        logic [31:0] eff;
        rst = 1'b1;
        new_request = 1'b0;
        op = OP_LW;
        base = '0;
        offset = '0;
        store_data = '0;
        id = '0;
        prev_local_load = 1'b0;
        prev_periph = 1'b0;
        fd = $fopen("sim/ls_unit_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", t_idx[num_tests],
                                t_op[num_tests], t_base[num_tests], t_off[num_tests],
                                t_data[num_tests], t_id[num_tests], t_kind[num_tests],
                                t_exp[num_tests], t_tval[num_tests]);
                    if (n == 9)
                        num_tests++;
                end
            end
            $fclose(fd);
            loaded = 1'b1;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        if (ready !== 1'b1 || wb_done !== 1'b0 || exc_valid !== 1'b0 || bus_req !== 1'b0) begin
            $display("Outputs after reset are not idle");
            errors++;
        end

        for (int i = 0; i < num_tests; i++) begin
            @(negedge clk);
            new_request = 1'b1;
            op = ls_op_t'(t_op[i][3:0]);
            base = t_base[i];
            offset = t_off[i][11:0];
            store_data = t_data[i];
            id = t_id[i][ID_W-1:0];
            eff = t_base[i] + {{20{t_off[i][11]}}, t_off[i][11:0]};
            // A load right behind a local load but to the peripheral waits one cycle
            exp_waits = (prev_local_load && t_kind[i] == 1 && eff[31]) ? 1 : 0;
            waits = 0;
            #1;
            while (!ready) begin
                @(negedge clk);
                #1;
                waits++;
            end
            // Accepted on the coming rising edge
            if (!prev_periph) begin
                hold_ok = 1'b1;
                compare_field(t_idx[i], "ready wait", exp_waits, waits, hold_ok);
            end
            if (t_kind[i] == 0) begin
                passed++;
                $display("Test %0d store accepted", t_idx[i]);
            end else begin
                q_test.push_back(i);
                q_cycle.push_back(cycle + 1);
                q_local.push_back(t_kind[i] == 2 || !eff[31]);
            end
            prev_local_load = t_kind[i] == 1 && !eff[31];
            prev_periph = t_kind[i] != 2 && eff[31];
        end
        @(negedge clk);
        new_request = 1'b0;

        for (int w = 0; w < 60 && q_test.size() > 0; w++)
            @(negedge clk);
        while (q_test.size() > 0) begin
            $display("Test %0d never produced its result pulse", t_idx[q_test.pop_front()]);
            void'(q_cycle.pop_front());
            void'(q_local.pop_front());
            errors++;
        end
        repeat (5) @(negedge clk);

        $display("%0d tests, %0d passed, %0d errors", num_tests, passed, errors);
        if (errors == 0 && num_tests > 0 && passed == num_tests) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/periph_responder.sv ====
// Peripheral memory model answering the four-phase req/ack handshake after random delays
`timescale 1ns/1ns
`default_nettype none

module periph_responder (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic                             bus_req,
    input  wire logic                             bus_we,
    input  wire logic [ls_config_pkg::XLEN-1:0]   bus_addr,
    input  wire logic [ls_config_pkg::XLEN/8-1:0] bus_be,
    input  wire logic [ls_config_pkg::XLEN-1:0]   bus_wdata,
    output logic                                  bus_ack,
    output logic [ls_config_pkg::XLEN-1:0]        bus_rdata
);
    import ls_config_pkg::*;

    logic [7:0] mem [0:1023];
    integer     seed;
    integer     delay;
    logic       armed;
    logic [9:0] word_base;

    initial begin
        seed = 67384;
        bus_ack = 1'b0;
        bus_rdata = '0;
        armed = 1'b0;
        for (int i = 0; i < 1024; i++)
            mem[i] = 8'h00;
    end

    always @(posedge clk) begin
        word_base = {bus_addr[9:2], 2'b00};
        if (rst) begin
            bus_ack   <= 1'b0;
            bus_rdata <= '0;
            armed     = 1'b0;
        end else if (bus_ack) begin
            // Release phase, ack follows req down
            if (!bus_req)
                bus_ack <= 1'b0;
        end else if (bus_req) begin
            if (!armed) begin
                armed = 1'b1;
                delay = $unsigned($random(seed)) % 4;
            end
            if (delay == 0) begin
                armed = 1'b0;
                bus_ack <= 1'b1;
                for (int b = 0; b < XLEN/8; b++) begin
                    if (bus_we && bus_be[b])
                        mem[word_base + b] = bus_wdata[8*b +: 8];
                    bus_rdata[8*b +: 8] <= mem[word_base + b];
                end
            end else begin
                delay = delay - 1;
            end
        end
    end

endmodule

`default_nettype wire
